//--- src/soc_pkg.sv
//////////////////////////////
// Bus widths, memory map and shared types of the SoC fabric
// The L2 window is exactly the size of the memory, no aliasing
//////////////////////////////

`default_nettype none

package soc_pkg;

  // Bus widths
  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 64;
  localparam int STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int APB_DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [STRB_WIDTH-1:0]     strb_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  // L2 memory geometry
  localparam int L2_NUM_WORDS   = 1024;
  localparam int L2_INDEX_WIDTH = $clog2(L2_NUM_WORDS);
  localparam int L2_OFFSET_BITS = $clog2(STRB_WIDTH);

  typedef logic [L2_INDEX_WIDTH-1:0] l2_index_t;

  //////////////////////////////
  // Memory map
  //////////////////////////////

  localparam addr_t DRAM_BASE   = 32'h8000_0000;
  localparam addr_t DRAM_LENGTH = 32'h0000_2000;
  localparam addr_t UART_BASE   = 32'hC000_0000;
  localparam addr_t UART_LENGTH = 32'h0000_1000;
  localparam addr_t CTRL_BASE   = 32'hD000_0000;
  localparam addr_t CTRL_LENGTH = 32'h0000_1000;

  // Router target codes
  typedef logic [1:0] target_t;

  localparam target_t TARGET_MEM  = 2'd0;
  localparam target_t TARGET_UART = 2'd1;
  localparam target_t TARGET_CTRL = 2'd2;
  localparam target_t TARGET_NONE = 2'd3;

  // Control register offsets inside the CTRL window
  localparam addr_t CTRL_EXIT_OFFSET      = 32'h00;
  localparam addr_t CTRL_CNT_EN_OFFSET    = 32'h08;
  localparam addr_t CTRL_DRAM_BASE_OFFSET = 32'h10;
  localparam addr_t CTRL_DRAM_END_OFFSET  = 32'h18;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage

`default_nettype wire

//--- src/soc_bus_router.sv
//////////////////////////////
// Single master router, one open UART transfer at a time
// Grants stall while the UART transfer is open
// Unmapped requests answer one cycle later with err_o
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module soc_bus_router import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  // Master side
  input  logic    req_i,
  input  logic    we_i,
  input  addr_t   addr_i,
  input  strb_t   be_i,
  input  data_t   wdata_i,
  output logic    gnt_o,
  output logic    rvalid_o,
  output data_t   rdata_o,
  output logic    err_o,
  // Target strobes
  output logic    mem_req_o,
  output logic    ctrl_req_o,
  output logic    uart_req_o,
  // Fields shared by all targets
  output logic    bus_we_o,
  output addr_t   bus_addr_o,
  output strb_t   bus_be_o,
  output data_t   bus_wdata_o,
  // Target responses
  input  logic    mem_rvalid_i,
  input  data_t   mem_rdata_i,
  input  logic    ctrl_rvalid_i,
  input  data_t   ctrl_rdata_i,
  input  logic    uart_rvalid_i,
  input  data_t   uart_rdata_i,
  input  logic    uart_err_i
);

  target_t target;
  logic    uart_busy_q;
  logic    err_q;

  // Addresses below base wrap to large offsets and miss the window
  function automatic logic in_window(addr_t addr, addr_t base, addr_t length);
    return (addr - base) < length;
  endfunction

  //////////////////////////////
  // Decode and grant
  //////////////////////////////

  always_comb begin
    if (in_window(addr_i, DRAM_BASE, DRAM_LENGTH)) begin
      target = TARGET_MEM;
    end else if (in_window(addr_i, UART_BASE, UART_LENGTH)) begin
      target = TARGET_UART;
    end else if (in_window(addr_i, CTRL_BASE, CTRL_LENGTH)) begin
      target = TARGET_CTRL;
    end else begin
      target = TARGET_NONE;
    end
  end

  assign gnt_o      = req_i && !uart_busy_q;
  assign mem_req_o  = gnt_o && (target == TARGET_MEM);
  assign uart_req_o = gnt_o && (target == TARGET_UART);
  assign ctrl_req_o = gnt_o && (target == TARGET_CTRL);

  assign bus_we_o    = we_i;
  assign bus_addr_o  = addr_i;
  assign bus_be_o    = be_i;
  assign bus_wdata_o = wdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      uart_busy_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      err_q <= gnt_o && (target == TARGET_NONE);
      if (uart_req_o) begin
        uart_busy_q <= 1'b1;
      end else if (uart_rvalid_i) begin
        uart_busy_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Response steering
  //////////////////////////////

  // At most one response strobe is high in any cycle
  assign rvalid_o = mem_rvalid_i || ctrl_rvalid_i || uart_rvalid_i || err_q;
  assign err_o    = err_q || (uart_rvalid_i && uart_err_i);

  always_comb begin
    if (mem_rvalid_i) begin
      rdata_o = mem_rdata_i;
    end else if (ctrl_rvalid_i) begin
      rdata_o = ctrl_rdata_i;
    end else if (uart_rvalid_i) begin
      rdata_o = uart_rdata_i;
    end else begin
      rdata_o = '0;
    end
  end

endmodule

`default_nettype wire

//--- src/l2_sram.sv
//////////////////////////////
// Single-port L2 memory, one-cycle read latency
// Contents are undefined until written
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module l2_sram import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  strb_t be_i,
  input  data_t wdata_i,
  output logic  rvalid_o,
  output data_t rdata_o
);

  data_t     mem [L2_NUM_WORDS];
  l2_index_t index;

  // Word index, byte offset dropped
  assign index = addr_i[L2_OFFSET_BITS +: L2_INDEX_WIDTH];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (be_i[b]) begin
          mem[index][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= we_i ? '0 : mem[index];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- src/uart_apb_bridge.sv
//////////////////////////////
// Bus to APB bridge for the external UART
// Accepts a new request only in APB_IDLE
// pwdata is the low word of wdata, no byte strobes on APB
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module uart_apb_bridge import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Bus side
  input  logic      req_i,
  input  logic      we_i,
  input  addr_t     addr_i,
  input  data_t     wdata_i,
  output logic      rvalid_o,
  output data_t     rdata_o,
  output logic      err_o,
  // APB side
  output logic      psel_o,
  output logic      penable_o,
  output logic      pwrite_o,
  output addr_t     paddr_o,
  output apb_data_t pwdata_o,
  input  apb_data_t prdata_i,
  input  logic      pready_i,
  input  logic      pslverr_i
);

  apb_state_e state_q;
  logic       we_q;
  addr_t      addr_q;
  apb_data_t  wdata_q;
  logic       done;

  assign done = (state_q == APB_ACCESS) && pready_i;

  //////////////////////////////
  // Phase FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= APB_IDLE;
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= done;
      err_o    <= done && pslverr_i;
      case (state_q)
        APB_IDLE: begin
          if (req_i) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: begin
          state_q <= APB_ACCESS;
        end
        APB_ACCESS: begin
          if (pready_i) begin
            state_q <= APB_IDLE;
          end
        end
        default: begin
          state_q <= APB_IDLE;
        end
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if ((state_q == APB_IDLE) && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i[APB_DATA_WIDTH-1:0];
    end
    if (done) begin
      rdata_o <= we_q ? '0 : data_t'(prdata_i);
    end
  end

  assign psel_o    = (state_q != APB_IDLE);
  assign penable_o = (state_q == APB_ACCESS);
  assign pwrite_o  = we_q;
  assign paddr_o   = addr_q;
  assign pwdata_o  = wdata_q;

endmodule

`default_nettype wire

//--- src/ctrl_registers.sv
//////////////////////////////
// SoC control registers, one-cycle response
// Unknown offsets read zero and drop writes
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ctrl_registers import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  strb_t be_i,
  input  data_t wdata_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output data_t exit_o,
  output data_t hw_cnt_en_o
);

  addr_t offset;
  data_t exit_q;
  data_t cnt_en_q;
  data_t rd_value;

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign offset = addr_i & (CTRL_LENGTH - 1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else if (req_i && we_i) begin
      if (offset == CTRL_EXIT_OFFSET) begin
        exit_q <= merge_bytes(exit_q, wdata_i, be_i);
      end
      if (offset == CTRL_CNT_EN_OFFSET) begin
        cnt_en_q <= merge_bytes(cnt_en_q, wdata_i, be_i);
      end
    end
  end

  // Read mux, window registers are constant
  always_comb begin
    case (offset)
      CTRL_EXIT_OFFSET:      rd_value = exit_q;
      CTRL_CNT_EN_OFFSET:    rd_value = cnt_en_q;
      CTRL_DRAM_BASE_OFFSET: rd_value = data_t'(DRAM_BASE);
      CTRL_DRAM_END_OFFSET:  rd_value = data_t'(DRAM_BASE + DRAM_LENGTH);
      default:               rd_value = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= we_i ? '0 : rd_value;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule

`default_nettype wire

//--- src/soc_top.sv
//////////////////////////////
// SoC fabric top, one bus master and three targets
// The UART itself sits outside, on the APB ports
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Master port
  input  logic      req_i,
  input  logic      we_i,
  input  addr_t     addr_i,
  input  strb_t     be_i,
  input  data_t     wdata_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output data_t     rdata_o,
  output logic      err_o,
  // Control outputs
  output data_t     exit_o,
  output data_t     hw_cnt_en_o,
  // UART APB port
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output addr_t     uart_paddr_o,
  output apb_data_t uart_pwdata_o,
  input  apb_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i
);

  logic  mem_req;
  logic  ctrl_req;
  logic  uart_req;
  logic  bus_we;
  addr_t bus_addr;
  strb_t bus_be;
  data_t bus_wdata;
  logic  mem_rvalid;
  data_t mem_rdata;
  logic  ctrl_rvalid;
  data_t ctrl_rdata;
  logic  uart_rvalid;
  data_t uart_rdata;
  logic  uart_err;

  soc_bus_router i_router (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .be_i          (be_i),
    .wdata_i       (wdata_i),
    .gnt_o         (gnt_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .mem_req_o     (mem_req),
    .ctrl_req_o    (ctrl_req),
    .uart_req_o    (uart_req),
    .bus_we_o      (bus_we),
    .bus_addr_o    (bus_addr),
    .bus_be_o      (bus_be),
    .bus_wdata_o   (bus_wdata),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .ctrl_rvalid_i (ctrl_rvalid),
    .ctrl_rdata_i  (ctrl_rdata),
    .uart_rvalid_i (uart_rvalid),
    .uart_rdata_i  (uart_rdata),
    .uart_err_i    (uart_err)
  );

  l2_sram i_l2_sram (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (mem_req),
    .we_i     (bus_we),
    .addr_i   (bus_addr),
    .be_i     (bus_be),
    .wdata_i  (bus_wdata),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

  uart_apb_bridge i_uart_bridge (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (uart_req),
    .we_i      (bus_we),
    .addr_i    (bus_addr),
    .wdata_i   (bus_wdata),
    .rvalid_o  (uart_rvalid),
    .rdata_o   (uart_rdata),
    .err_o     (uart_err),
    .psel_o    (uart_psel_o),
    .penable_o (uart_penable_o),
    .pwrite_o  (uart_pwrite_o),
    .paddr_o   (uart_paddr_o),
    .pwdata_o  (uart_pwdata_o),
    .prdata_i  (uart_prdata_i),
    .pready_i  (uart_pready_i),
    .pslverr_i (uart_pslverr_i)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (ctrl_req),
    .we_i        (bus_we),
    .addr_i      (bus_addr),
    .be_i        (bus_be),
    .wdata_i     (bus_wdata),
    .rvalid_o    (ctrl_rvalid),
    .rdata_o     (ctrl_rdata),
    .exit_o      (exit_o),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

`default_nettype wire

//--- verif/tb_soc_top.sv
//////////////////////////////
// Bus master and UART APB slave model around soc_top
// Responses are checked in grant order against reference models
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_soc_top import soc_pkg::*; ();

  localparam int    TIMEOUT      = 50;
  localparam addr_t APB_ERR_ADDR = UART_BASE + 32'h38;

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      req_i;
  logic      we_i;
  addr_t     addr_i;
  strb_t     be_i;
  data_t     wdata_i;
  logic      gnt_o, rvalid_o, err_o;
  data_t     rdata_o, exit_o, hw_cnt_en_o;
  logic      uart_psel_o, uart_penable_o, uart_pwrite_o;
  addr_t     uart_paddr_o;
  apb_data_t uart_pwdata_o, uart_prdata_i;
  logic      uart_pready_i, uart_pslverr_i;

  // Reference state and expected responses
  data_t       mem_ref [L2_NUM_WORDS];
  data_t       exit_ref, cnt_en_ref;
  apb_data_t   uart_ref [4];
  apb_data_t   apb_regs [8];
  l2_index_t   picks [16];
  data_t       exp_data_q [$];
  logic        exp_err_q [$];
  int          exp_due_q [$];
  logic [31:0] stim_seed, apb_seed;
  addr_t       apb_exp_addr;
  logic        apb_exp_write;
  apb_data_t   apb_exp_wdata;
  logic [1:0]  wait_left;
  logic        prev_psel;
  int          uart_due;
  int          cycle, tests, failed_tests, test_base;
  int          main_errors, resp_errors, apb_errors;
  data_t       wd;
  strb_t       be;
  int          k, total;
  addr_t       ua;

  soc_top UUT (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [31:0] rand32();
    stim_seed = lcg_next(stim_seed);
    return stim_seed;
  endfunction

  function data_t rand64();
    data_t v;
    v[63:32] = rand32();
    v[31:0]  = rand32();
    return v;
  endfunction

  function automatic data_t byte_merge(input data_t old_val, input data_t new_val,
                                       input strb_t en);
    data_t mask;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      mask[i*8 +: 8] = {8{en[i]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic addr_t l2_addr(input l2_index_t idx);
    return DRAM_BASE + (addr_t'(idx) << 3);
  endfunction

  function automatic int flag_mismatch(input logic cond, input string msg);
    int bad;
    bad = 0;
    assert (cond) else begin
      $display("ERROR at %0d ns: %s", $time, msg);
      bad = 1;
    end
    return bad;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0d ns: %s", $time, what);
    $display("test failed");
    $finish;
  endtask

  task automatic finish_test(input string name);
    int sum;
    sum = main_errors + resp_errors + apb_errors;
    tests++;
    if (sum != test_base) begin
      failed_tests++;
    end
    $display("%s done, %0d errors", name, sum - test_base);
    test_base = sum;
  endtask

  //////////////////////////////
  // Bus master
  //////////////////////////////

  // Called 1 ns after a rising edge and returns 1 ns after the transfer edge
  task automatic issue(input logic we, input addr_t addr, input strb_t en, input data_t data,
                       input data_t exp_data, input logic exp_err, input logic via_uart);
    int waited;
    waited  = 0;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = en;
    wdata_i = data;
    @(negedge clk_i);
    while (!gnt_o) begin
      if (waited == TIMEOUT) begin
        abort_on_timeout("request was never granted");
      end
      waited++;
      @(negedge clk_i);
    end
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    exp_due_q.push_back(via_uart ? -1 : cycle + 1);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_due_q.size() != 0) begin
      if (waited == TIMEOUT) begin
        abort_on_timeout("a granted request got no response");
      end
      waited++;
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin
    cycle = 0;
    forever begin
      @(posedge clk_i);
      cycle++;
    end
  end

  // Response checker sampling at the falling edge
  initial begin
    data_t exp_d;
    logic  exp_e;
    int    due;
    resp_errors = 0;
    forever begin
      @(negedge clk_i);
      if (!reset_i) begin
        resp_errors += flag_mismatch(!(uart_psel_o && gnt_o), "grant while UART transfer open");
        resp_errors += flag_mismatch(rvalid_o || !err_o, "err_o high without rvalid_o");
        if (rvalid_o && exp_due_q.size() == 0) begin
          resp_errors += flag_mismatch(1'b0, "response without a granted request");
        end else if (rvalid_o) begin
          exp_d = exp_data_q.pop_front();
          exp_e = exp_err_q.pop_front();
          due   = exp_due_q.pop_front();
          resp_errors += flag_mismatch(rdata_o == exp_d,
                                       $sformatf("rdata %h, expected %h", rdata_o, exp_d));
          resp_errors += flag_mismatch(err_o == exp_e,
                                       $sformatf("err_o %b, expected %b", err_o, exp_e));
          if (due < 0) begin
            resp_errors += flag_mismatch(!gnt_o, "grant in the UART response cycle");
            resp_errors += flag_mismatch(cycle == uart_due,
                                         $sformatf("UART response in cycle %0d, expected %0d",
                                                   cycle, uart_due));
          end else begin
            resp_errors += flag_mismatch(cycle == due,
                                         $sformatf("response in cycle %0d, expected %0d",
                                                   cycle, due));
          end
        end
      end
    end
  end

  //////////////////////////////
  // APB slave model
  //////////////////////////////

  initial begin
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    apb_errors     = 0;
    prev_psel      = 1'b0;
    wait_left      = 2'd0;
    uart_due       = -1;
    apb_seed       = 32'd46;
    for (int i = 0; i < 8; i++) begin
      apb_regs[i] = '0;
    end
    forever begin
      @(posedge clk_i);
      #1;
      uart_pready_i  = 1'b0;
      uart_pslverr_i = 1'b0;
      uart_prdata_i  = '0;
      if (!reset_i && uart_psel_o) begin
        apb_errors += flag_mismatch(uart_paddr_o == apb_exp_addr && uart_pwrite_o == apb_exp_write,
                                    $sformatf("APB paddr %h or pwrite wrong", uart_paddr_o));
        if (!uart_penable_o) begin
          apb_errors += flag_mismatch(!apb_exp_write || uart_pwdata_o == apb_exp_wdata,
                                      $sformatf("pwdata %h, expected %h",
                                                uart_pwdata_o, apb_exp_wdata));
          // Wait states for the coming access phase
          apb_seed  = lcg_next(apb_seed);
          wait_left = apb_seed[21:20];
        end else begin
          apb_errors += flag_mismatch(prev_psel, "penable without a setup phase");
          if (wait_left != 2'd0) begin
            wait_left = wait_left - 2'd1;
          end else begin
            uart_pready_i = 1'b1;
            // Bus response belongs to the next cycle
            uart_due      = cycle + 1;
            if (uart_paddr_o == APB_ERR_ADDR) begin
              uart_pslverr_i = 1'b1;
            end else if (uart_pwrite_o) begin
              apb_regs[uart_paddr_o[5:3]] = uart_pwdata_o;
            end else begin
              uart_prdata_i = apb_regs[uart_paddr_o[5:3]];
            end
          end
        end
      end else begin
        apb_errors += flag_mismatch(!uart_penable_o, "penable without psel");
      end
      prev_psel = uart_psel_o;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    stim_seed     = 32'd46;
    reset_i       = 1'b1;
    req_i         = 1'b0;
    we_i          = 1'b0;
    addr_i        = '0;
    be_i          = '0;
    wdata_i       = '0;
    apb_exp_addr  = '0;
    apb_exp_write = 1'b0;
    apb_exp_wdata = '0;
    exit_ref      = '0;
    cnt_en_ref    = '0;
    main_errors   = 0;
    tests         = 0;
    failed_tests  = 0;
    test_base     = 0;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    main_errors += flag_mismatch(!gnt_o && !rvalid_o && !err_o, "bus outputs not low in reset");
    main_errors += flag_mismatch(!uart_psel_o && !uart_penable_o, "APB select not low in reset");
    main_errors += flag_mismatch(exit_o == '0 && hw_cnt_en_o == '0, "control outputs not zero");
    @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    finish_test("reset");

    // Full-word fill, random byte-enabled updates, back-to-back reads
    for (int i = 0; i < 16; i++) begin
      picks[i] = l2_index_t'(rand32() >> 13);
      wd = rand64();
      mem_ref[picks[i]] = wd;
      issue(1'b1, l2_addr(picks[i]), 8'hFF, wd, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 24; i++) begin
      k  = int'((rand32() >> 20) % 32'd16);
      wd = rand64();
      be = strb_t'(rand32() >> 9);
      mem_ref[picks[k]] = byte_merge(mem_ref[picks[k]], wd, be);
      issue(1'b1, l2_addr(picks[k]), be, wd, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      issue(1'b0, l2_addr(picks[i]), '0, '0, mem_ref[picks[i]], 1'b0, 1'b0);
    end
    drain();
    finish_test("l2_memory");

    wd = rand64();
    exit_ref = byte_merge(exit_ref, wd, 8'h3C);
    issue(1'b1, CTRL_BASE + CTRL_EXIT_OFFSET, 8'h3C, wd, '0, 1'b0, 1'b0);
    wd = rand64();
    cnt_en_ref = wd;
    issue(1'b1, CTRL_BASE + CTRL_CNT_EN_OFFSET, 8'hFF, wd, '0, 1'b0, 1'b0);
    issue(1'b1, CTRL_BASE + 32'h20, 8'hFF, rand64(), '0, 1'b0, 1'b0);
    drain();
    main_errors += flag_mismatch(exit_o == exit_ref, $sformatf("exit_o %h", exit_o));
    main_errors += flag_mismatch(hw_cnt_en_o == cnt_en_ref,
                                 $sformatf("hw_cnt_en_o %h", hw_cnt_en_o));
    issue(1'b0, CTRL_BASE + CTRL_EXIT_OFFSET, '0, '0, exit_ref, 1'b0, 1'b0);
    issue(1'b0, CTRL_BASE + CTRL_CNT_EN_OFFSET, '0, '0, cnt_en_ref, 1'b0, 1'b0);
    issue(1'b0, CTRL_BASE + CTRL_DRAM_BASE_OFFSET, '0, '0, 64'h8000_0000, 1'b0, 1'b0);
    issue(1'b0, CTRL_BASE + CTRL_DRAM_END_OFFSET, '0, '0, 64'h8000_2000, 1'b0, 1'b0);
    issue(1'b0, CTRL_BASE + 32'h20, '0, '0, '0, 1'b0, 1'b0);
    drain();
    finish_test("ctrl_regs");

    for (int i = 0; i < 4; i++) begin
      wd = rand64();
      ua = UART_BASE + addr_t'(i * 8);
      uart_ref[i]   = wd[31:0];
      apb_exp_addr  = ua;
      apb_exp_write = 1'b1;
      apb_exp_wdata = wd[31:0];
      issue(1'b1, ua, 8'hFF, wd, '0, 1'b0, 1'b1);
      drain();
    end
    // UART read between two L2 reads where the second one stalls
    for (int i = 0; i < 4; i++) begin
      issue(1'b0, l2_addr(picks[i]), '0, '0, mem_ref[picks[i]], 1'b0, 1'b0);
      apb_exp_addr  = UART_BASE + addr_t'(i * 8);
      apb_exp_write = 1'b0;
      issue(1'b0, apb_exp_addr, '0, '0, {32'h0, uart_ref[i]}, 1'b0, 1'b1);
      issue(1'b0, l2_addr(picks[i + 4]), '0, '0, mem_ref[picks[i + 4]], 1'b0, 1'b0);
      drain();
    end
    apb_exp_addr  = APB_ERR_ADDR;
    apb_exp_write = 1'b1;
    apb_exp_wdata = 32'h1234_5678;
    issue(1'b1, APB_ERR_ADDR, 8'hFF, 64'h1234_5678, '0, 1'b1, 1'b1);
    drain();
    apb_exp_write = 1'b0;
    issue(1'b0, APB_ERR_ADDR, '0, '0, '0, 1'b1, 1'b1);
    drain();
    finish_test("uart_apb");

    // Index 0 is where a wrapped DRAM address would land
    wd = rand64();
    mem_ref[0] = wd;
    issue(1'b1, DRAM_BASE, 8'hFF, wd, '0, 1'b0, 1'b0);
    issue(1'b1, 32'h8000_2000, 8'hFF, ~wd, '0, 1'b1, 1'b0);
    issue(1'b1, 32'hD000_1000, 8'hFF, ~wd, '0, 1'b1, 1'b0);
    issue(1'b1, 32'hC000_1000, 8'hFF, ~wd, '0, 1'b1, 1'b0);
    issue(1'b0, 32'h0000_0100, '0, '0, '0, 1'b1, 1'b0);
    issue(1'b0, 32'hFFFF_FFF8, '0, '0, '0, 1'b1, 1'b0);
    issue(1'b0, DRAM_BASE, '0, '0, mem_ref[0], 1'b0, 1'b0);
    drain();
    main_errors += flag_mismatch(exit_o == exit_ref, "exit_o changed by unmapped write");
    main_errors += flag_mismatch(hw_cnt_en_o == cnt_en_ref,
                                 "hw_cnt_en_o changed by unmapped write");
    finish_test("unmapped");

    total = main_errors + resp_errors + apb_errors;
    $display("tests: %0d, tests with errors: %0d, errors: %0d", tests, failed_tests, total);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/soc_pkg.sv
src/soc_bus_router.sv
src/l2_sram.sv
src/uart_apb_bridge.sv
src/ctrl_registers.sv
src/soc_top.sv
verif/tb_soc_top.sv

//--- Makefile
# Verilator build and run of the SoC fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0

.PHONY: sim clean

# Pass or fail comes from the log, not from the exit status of the binary
sim:
	$(VERILATOR) --binary --assert $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
